//--- Bender.yml
package:
  name: msx_io

sources:
  - files:
      - hdl/msx_pkg.sv
      - hdl/bus_cycle_req.sv
      - hdl/io_port_decode.sv
      - hdl/vdp_lite.sv
      - hdl/rtc_lite.sv
      - hdl/msx_io.sv
  - target: simulation
    files:
      - verification/msx_io_chk.sv
      - verification/msx_io_tb.sv

//--- hdl/bus_cycle_req.sv
`timescale 1ns/1ps

module bus_cycle_req (
   input  logic              clk21m,
   input  logic              reset,
   input  msx_pkg::cpu_bus_t bus,
   output logic              req
);

   logic active;
   logic iack;

   // Memory or I/O cycle with a read or write strobe
   assign active = ~(bus.iorq_n & bus.mreq_n) & ~(bus.rd_n & bus.wr_n);

   // First clock of the access only
   assign req = active & ~iack;

   always_ff @(posedge clk21m) begin
      if (reset) begin
         iack <= 1'b0;
      end else begin
         if (bus.iorq_n && bus.mreq_n) begin
            iack <= 1'b0;
         end else if (req) begin
            iack <= 1'b1;
         end
      end
   end

endmodule

//--- hdl/io_port_decode.sv
`timescale 1ns/1ps

module io_port_decode #(
   parameter logic [7:0] VDP_PORT_BASE = msx_pkg::VDP_PORT_DEFAULT,
   parameter logic [7:0] RTC_PORT_BASE = msx_pkg::RTC_PORT_DEFAULT
) (
   input  msx_pkg::cpu_bus_t bus,
   input  logic              req,
   input  logic [7:0]        vdp_dout,
   input  logic [7:0]        rtc_dout,
   output logic              vdp_req,
   output logic              rtc_req,
   output logic [7:0]        d_to_cpu,
   output logic              data_bus_rq
);

   logic io_cycle;
   logic vdp_sel;
   logic rtc_sel;

   // Interrupt acknowledge cycles have m1_n low
   assign io_cycle = ~bus.iorq_n & bus.m1_n;

   // Video ports mirror over eight addresses, clock over two
   assign vdp_sel = io_cycle & (bus.addr[7:3] == VDP_PORT_BASE[7:3]);
   assign rtc_sel = io_cycle & (bus.addr[7:1] == RTC_PORT_BASE[7:1]);

   assign vdp_req = req & vdp_sel;
   assign rtc_req = req & rtc_sel;

   always_comb begin
      if (bus.rd_n) begin
         d_to_cpu = 8'hFF;
      end else if (vdp_sel) begin
         d_to_cpu = vdp_dout;
      end else if (rtc_sel) begin
         d_to_cpu = rtc_dout;
      end else begin
         d_to_cpu = 8'hFF;
      end
   end

   assign data_bus_rq = ~bus.rd_n & (vdp_sel | rtc_sel);

endmodule

//--- hdl/msx_io.sv
`timescale 1ns/1ps

module msx_io #(
   parameter logic [7:0] VDP_PORT_BASE     = msx_pkg::VDP_PORT_DEFAULT,
   parameter logic [7:0] RTC_PORT_BASE     = msx_pkg::RTC_PORT_DEFAULT,
   parameter int         RTC_TICKS_PER_SEC = msx_pkg::RTC_TICKS_DEFAULT
) (
   input  logic               clk21m,
   input  logic               reset,
   input  msx_pkg::cpu_bus_t  bus,
   input  logic               ce_10hz,
   input  logic               frame_tick,
   input  msx_pkg::rtc_time_t rtc_time,
   input  logic [7:0]         vram_di_lo,
   input  logic [7:0]         vram_di_hi,
   output logic [7:0]         d_to_cpu,
   output logic               data_bus_rq,
   output logic               vdp_int_n,
   output msx_pkg::vram_bus_t vram
);

   logic       req;
   logic       vdp_req;
   logic       rtc_req;
   logic [7:0] vdp_dout;
   logic [7:0] rtc_dout;

   bus_cycle_req u_req (
      .clk21m (clk21m),
      .reset  (reset),
      .bus    (bus),
      .req    (req)
   );

   io_port_decode #(
      .VDP_PORT_BASE (VDP_PORT_BASE),
      .RTC_PORT_BASE (RTC_PORT_BASE)
   ) u_decode (
      .bus         (bus),
      .req         (req),
      .vdp_dout    (vdp_dout),
      .rtc_dout    (rtc_dout),
      .vdp_req     (vdp_req),
      .rtc_req     (rtc_req),
      .d_to_cpu    (d_to_cpu),
      .data_bus_rq (data_bus_rq)
   );

   vdp_lite u_vdp (
      .clk21m     (clk21m),
      .reset      (reset),
      .req        (vdp_req),
      .bus        (bus),
      .frame_tick (frame_tick),
      .vram_di_lo (vram_di_lo),
      .vram_di_hi (vram_di_hi),
      .dout       (vdp_dout),
      .int_n      (vdp_int_n),
      .vram       (vram)
   );

   rtc_lite #(
      .RTC_TICKS_PER_SEC (RTC_TICKS_PER_SEC)
   ) u_rtc (
      .clk21m   (clk21m),
      .reset    (reset),
      .req      (rtc_req),
      .bus      (bus),
      .ce_10hz  (ce_10hz),
      .rtc_time (rtc_time),
      .dout     (rtc_dout)
   );

endmodule

//--- hdl/msx_pkg.sv
package msx_pkg;

   // Z80 bus as seen by the I/O glue
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        wr_n;
      logic        rd_n;
      logic        iorq_n;
      logic        mreq_n;
      logic        m1_n;
      logic [2:0]  spare;
   } cpu_bus_t;

   // Preset time, packed BCD
   typedef struct packed {
      logic [7:0] hour;
      logic [7:0] min;
      logic [7:0] sec;
   } rtc_time_t;

   // VRAM side driven by the VDP port
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        we_lo;
      logic        we_hi;
   } vram_bus_t;

   localparam logic [7:0] VDP_PORT_DEFAULT  = 8'h98;
   localparam logic [7:0] RTC_PORT_DEFAULT  = 8'hB4;
   localparam int         RTC_TICKS_DEFAULT = 10;

endpackage

//--- hdl/rtc_lite.sv
`timescale 1ns/1ps

module rtc_lite #(
   parameter int RTC_TICKS_PER_SEC = msx_pkg::RTC_TICKS_DEFAULT
) (
   input  logic               clk21m,
   input  logic               reset,
   input  logic               req,
   input  msx_pkg::cpu_bus_t  bus,
   input  logic               ce_10hz,
   input  msx_pkg::rtc_time_t rtc_time,
   output logic [7:0]         dout
);

   localparam int TW = (RTC_TICKS_PER_SEC > 1) ? $clog2(RTC_TICKS_PER_SEC) : 1;

   logic [3:0]    regs [16];
   logic [3:0]    idx;
   logic [TW-1:0] tick_cnt;
   logic          sec_tick;
   logic [7:0]    sec_v;
   logic [7:0]    min_v;
   logic [7:0]    hr_v;

   // Two-digit BCD increment, wraps to 00 after last
   function automatic logic [7:0] bcd_next(input logic [7:0] v, input logic [7:0] last);
      if (v == last) begin
         return 8'h00;
      end else if (v[3:0] == 4'd9) begin
         return {v[7:4] + 4'd1, 4'd0};
      end else begin
         return {v[7:4], v[3:0] + 4'd1};
      end
   endfunction

   assign sec_v = {regs[1], regs[0]};
   assign min_v = {regs[3], regs[2]};
   assign hr_v  = {regs[5], regs[4]};

   assign sec_tick = ce_10hz & (tick_cnt == TW'(RTC_TICKS_PER_SEC - 1));

   // Upper nibble reads as ones
   assign dout = {4'hF, regs[idx]};

   always_ff @(posedge clk21m) begin
      if (reset) begin
         idx      <= 4'd0;
         tick_cnt <= '0;
         regs[0]  <= rtc_time.sec[3:0];
         regs[1]  <= rtc_time.sec[7:4];
         regs[2]  <= rtc_time.min[3:0];
         regs[3]  <= rtc_time.min[7:4];
         regs[4]  <= rtc_time.hour[3:0];
         regs[5]  <= rtc_time.hour[7:4];
         for (int i = 6; i < 16; i++) begin
            regs[i] <= 4'h0;
         end
      end else begin
         if (req && !bus.wr_n) begin
            if (!bus.addr[0]) begin
               idx <= bus.dout[3:0];
            end else begin
               regs[idx] <= bus.dout[3:0];
            end
         end

         if (ce_10hz) begin
            tick_cnt <= sec_tick ? '0 : tick_cnt + TW'(1);
         end

         // Carry ripples seconds to minutes to hours
         if (sec_tick) begin
            {regs[1], regs[0]} <= bcd_next(sec_v, 8'h59);
            if (sec_v == 8'h59) begin
               {regs[3], regs[2]} <= bcd_next(min_v, 8'h59);
               if (min_v == 8'h59) begin
                  {regs[5], regs[4]} <= bcd_next(hr_v, 8'h23);
               end
            end
         end
      end
   end

endmodule

//--- hdl/vdp_lite.sv
`timescale 1ns/1ps

module vdp_lite (
   input  logic               clk21m,
   input  logic               reset,
   input  logic               req,
   input  msx_pkg::cpu_bus_t  bus,
   input  logic               frame_tick,
   input  logic [7:0]         vram_di_lo,
   input  logic [7:0]         vram_di_hi,
   output logic [7:0]         dout,
   output logic               int_n,
   output msx_pkg::vram_bus_t vram
);

   logic        wr_acc;
   logic        rd_acc;
   logic        vram_we;
   logic [16:0] vaddr;
   logic        toggle;
   logic [7:0]  latch;
   logic [7:0]  r1;
   logic [2:0]  r14;
   logic        prefetch;
   logic [7:0]  rd_buf;
   logic        int_flag;
   logic        rd_hold;
   logic [7:0]  dout_live;
   logic [7:0]  dout_hold;

   assign wr_acc  = req & ~bus.wr_n;
   assign rd_acc  = req & ~bus.rd_n;
   assign vram_we = wr_acc & ~bus.addr[0];

   // Bit 16 selects the bank
   assign vram.addr  = vaddr[15:0];
   assign vram.dout  = bus.dout;
   assign vram.we_lo = vram_we & ~vaddr[16];
   assign vram.we_hi = vram_we & vaddr[16];

   // Interrupt enable is R#1 bit 5
   assign int_n = ~(int_flag & r1[5]);

   // Port +1 gives S#0
   assign dout_live = bus.addr[0] ? {int_flag, 7'b0000000} : rd_buf;

   // Keep the value seen at the request edge for the rest of the read
   assign dout = rd_hold ? dout_hold : dout_live;

   always_ff @(posedge clk21m) begin
      if (reset) begin
         vaddr    <= 17'd0;
         toggle   <= 1'b0;
         r1       <= 8'h00;
         r14      <= 3'd0;
         prefetch <= 1'b0;
         int_flag <= 1'b0;
         rd_hold  <= 1'b0;
      end else begin
         prefetch <= 1'b0;
         if (vram_we || prefetch) begin
            vaddr <= vaddr + 17'd1;
         end
         if (rd_acc && !bus.addr[0]) begin
            prefetch <= 1'b1;
         end

         // Two-byte sequence on port +1
         if (wr_acc && bus.addr[0]) begin
            toggle <= ~toggle;
            if (toggle) begin
               if (bus.dout[7]) begin
                  case (bus.dout[5:0])
                     6'd1:    r1  <= latch;
                     6'd14:   r14 <= latch[2:0];
                     default: ;
                  endcase
               end else begin
                  vaddr    <= {r14, bus.dout[5:0], latch};
                  prefetch <= ~bus.dout[6];
               end
            end
         end

         // Status read acknowledges the frame interrupt
         if (rd_acc && bus.addr[0]) begin
            toggle   <= 1'b0;
            int_flag <= 1'b0;
         end
         if (frame_tick) begin
            int_flag <= 1'b1;
         end

         if (rd_acc) begin
            rd_hold <= 1'b1;
         end else if (bus.rd_n) begin
            rd_hold <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk21m) begin
      if (wr_acc && bus.addr[0] && !toggle) begin
         latch <= bus.dout;
      end
      // Read-ahead from the addressed bank
      if (prefetch) begin
         rd_buf <= vaddr[16] ? vram_di_hi : vram_di_lo;
      end
      if (!rd_hold) begin
         dout_hold <= dout_live;
      end
   end

endmodule

//--- msx_io.f
hdl/msx_pkg.sv
hdl/bus_cycle_req.sv
hdl/io_port_decode.sv
hdl/vdp_lite.sv
hdl/rtc_lite.sv
hdl/msx_io.sv
verification/msx_io_chk.sv
verification/msx_io_tb.sv

//--- verification/msx_io_chk.sv
`timescale 1ns/1ps

module msx_io_chk (
   input logic               clk21m,
   input logic               reset,
   input msx_pkg::cpu_bus_t  bus,
   input msx_pkg::vram_bus_t vram,
   input logic               data_bus_rq,
   input logic               req
);

   int fail_count = 0;

   // One bank written at a time
   a_one_bank: assert property (@(posedge clk21m) disable iff (reset)
      !(vram.we_lo && vram.we_hi))
      else begin
         fail_count++;
         $error("VRAM write strobes of both banks high together");
      end

   a_rq_on_read: assert property (@(posedge clk21m) disable iff (reset)
      data_bus_rq |-> !bus.rd_n)
      else begin
         fail_count++;
         $error("data_bus_rq high without a read strobe");
      end

   // Single request pulse per bus cycle
   a_req_pulse: assert property (@(posedge clk21m) disable iff (reset)
      req |=> !req)
      else begin
         fail_count++;
         $error("req high on two cycles in a row");
      end

endmodule

//--- verification/msx_io_tb.sv
`timescale 1ns/1ps

module msx_io_tb;
   import msx_pkg::*;

   // Most of the 2500 or so cycles go to the RTC ticks
   localparam int CYCLE_LIMIT = 4000;

   logic       clk21m;
   logic       reset;
   cpu_bus_t   bus;
   logic       ce_10hz;
   logic       frame_tick;
   rtc_time_t  rtc_time;
   logic [7:0] vram_di_lo;
   logic [7:0] vram_di_hi;
   logic [7:0] d_to_cpu;
   logic       data_bus_rq;
   logic       vdp_int_n;
   vram_bus_t  vram;

   logic [7:0] bank_lo [65536];
   logic [7:0] bank_hi [65536];
   logic       we_lo_seen;
   int         cycles;
   integer     seed;

   msx_io u_dut (
      .clk21m      (clk21m),
      .reset       (reset),
      .bus         (bus),
      .ce_10hz     (ce_10hz),
      .frame_tick  (frame_tick),
      .rtc_time    (rtc_time),
      .vram_di_lo  (vram_di_lo),
      .vram_di_hi  (vram_di_hi),
      .d_to_cpu    (d_to_cpu),
      .data_bus_rq (data_bus_rq),
      .vdp_int_n   (vdp_int_n),
      .vram        (vram)
   );

   bind msx_io msx_io_chk u_chk (
      .clk21m      (clk21m),
      .reset       (reset),
      .bus         (bus),
      .vram        (vram),
      .data_bus_rq (data_bus_rq),
      .req         (req)
   );

   initial begin
      clk21m = 1'b0;
      forever #20 clk21m = ~clk21m;
   end

   // Two 64 KB banks read combinationally at the VRAM address
   assign vram_di_lo = bank_lo[vram.addr];
   assign vram_di_hi = bank_hi[vram.addr];

   always @(posedge clk21m) begin
      if (vram.we_lo) begin
         bank_lo[vram.addr] <= vram.dout;
         we_lo_seen <= 1'b1;
      end
      if (vram.we_hi) begin
         bank_hi[vram.addr] <= vram.dout;
      end
   end

   always @(posedge clk21m) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         $display("TEST FAILED");
         $fatal(1, "Simulation timed out");
      end
   end

   task automatic check_byte(input string name, input logic [7:0] got,
                             input logic [7:0] want);
      if (got !== want) begin
         $display("[ERROR] %0t %s got %02h expected %02h", $time, name, got, want);
         $display("TEST FAILED");
         $fatal(1, "Byte mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      if (got !== want) begin
         $display("[ERROR] %0t %s got %b expected %b", $time, name, got, want);
         $display("TEST FAILED");
         $fatal(1, "Bit mismatch");
      end
   endtask

   task automatic check_vram(input vram_bus_t got, input vram_bus_t want);
      if (got.addr !== want.addr) begin
         $display("[ERROR] %0t vram.addr got %04h expected %04h", $time, got.addr,
                  want.addr);
         $display("TEST FAILED");
         $fatal(1, "VRAM address mismatch");
      end
      check_byte("vram.dout", got.dout, want.dout);
      check_bit("vram.we_lo", got.we_lo, want.we_lo);
      check_bit("vram.we_hi", got.we_hi, want.we_hi);
   endtask

   // Seconds since midnight from packed BCD
   function automatic int bcd_secs(input rtc_time_t t);
      return (t.hour[7:4] * 10 + t.hour[3:0]) * 3600
           + (t.min[7:4] * 10 + t.min[3:0]) * 60
           + t.sec[7:4] * 10 + t.sec[3:0];
   endfunction

   // Clock register nibble r for a time in seconds
   function automatic logic [3:0] time_digit(input int tot, input int r);
      int field;
      case (r / 2)
         0:       field = tot % 60;
         1:       field = (tot / 60) % 60;
         default: field = (tot / 3600) % 24;
      endcase
      return 4'((r % 2 == 0) ? field % 10 : field / 10);
   endfunction

   task automatic drive_bus(input logic [15:0] addr, input logic [7:0] data,
                            input logic wr, input logic io, input logic m1_low);
      @(negedge clk21m);
      bus.addr   = addr;
      bus.dout   = data;
      bus.wr_n   = ~wr;
      bus.rd_n   = wr;
      bus.iorq_n = ~io;
      bus.mreq_n = io;
      bus.m1_n   = ~m1_low;
   endtask

   // Strobes held for three cycles and sampled just before release
   task automatic end_cycle(output logic [7:0] rdata, output logic rq);
      repeat (3) @(negedge clk21m);
      rdata      = d_to_cpu;
      rq         = data_bus_rq;
      bus.wr_n   = 1'b1;
      bus.rd_n   = 1'b1;
      bus.iorq_n = 1'b1;
      bus.mreq_n = 1'b1;
      bus.m1_n   = 1'b1;
   endtask

   task automatic io_write(input logic [7:0] port, input logic [7:0] data);
      logic [7:0] d;
      logic       rq;
      drive_bus({8'h00, port}, data, 1'b1, 1'b1, 1'b0);
      end_cycle(d, rq);
   endtask

   task automatic io_read(input logic [7:0] port, output logic [7:0] d, output logic rq);
      drive_bus({8'h00, port}, 8'h00, 1'b0, 1'b1, 1'b0);
      end_cycle(d, rq);
   endtask

   task automatic vram_write(input vram_bus_t want);
      logic [7:0] d;
      logic       rq;
      drive_bus(16'h0098, want.dout, 1'b1, 1'b1, 1'b0);
      #1;
      check_vram(vram, want);
      end_cycle(d, rq);
   endtask

   task automatic vdp_reg_write(input logic [5:0] num, input logic [7:0] val);
      io_write(8'h99, val);
      io_write(8'h99, {2'b10, num});
   endtask

   task automatic vdp_addr_set(input logic [13:0] addr, input logic for_write);
      io_write(8'h99, addr[7:0]);
      io_write(8'h99, {1'b0, for_write, addr[13:8]});
   endtask

   task automatic frame_pulse();
      @(negedge clk21m);
      frame_tick = 1'b1;
      @(negedge clk21m);
      frame_tick = 1'b0;
   endtask

   task automatic tick_pulse();
      @(negedge clk21m);
      ce_10hz = 1'b1;
      @(negedge clk21m);
      ce_10hz = 1'b0;
      repeat (98) @(negedge clk21m);
   endtask

   task automatic reset_state();
      vram_bus_t  want;
      logic [7:0] d;
      logic       rq;
      want = '{addr: 16'h0000, dout: 8'h00, we_lo: 1'b0, we_hi: 1'b0};
      check_bit("vdp_int_n", vdp_int_n, 1'b1);
      check_bit("data_bus_rq", data_bus_rq, 1'b0);
      check_vram(vram, want);
      check_byte("d_to_cpu", d_to_cpu, 8'hFF);
      io_read(8'h10, d, rq);
      check_byte("d_to_cpu", d, 8'hFF);
      check_bit("data_bus_rq", rq, 1'b0);
   endtask

   task automatic vram_access();
      logic [7:0]  wdata [4];
      logic [2:0]  bank_sel;
      logic [16:0] base;
      vram_bus_t   want;
      logic [7:0]  d;
      logic        rq;
      // R#14 supplies address bits 16 to 14
      bank_sel = 3'd5;
      base     = {bank_sel, 14'h0100};
      vdp_reg_write(6'd14, {5'd0, bank_sel});
      vdp_addr_set(14'h0100, 1'b1);
      for (int i = 0; i < 4; i++) begin
         wdata[i] = 8'($random(seed));
         want = '{addr: 16'(base + i), dout: wdata[i], we_lo: 1'b0, we_hi: 1'b1};
         vram_write(want);
         check_byte("bank_hi", bank_hi[16'(base + i)], wdata[i]);
      end
      check_bit("we_lo_seen", we_lo_seen, 1'b0);
      vdp_addr_set(14'h0100, 1'b0);
      for (int i = 0; i < 4; i++) begin
         io_read(8'h98, d, rq);
         check_byte("d_to_cpu", d, wdata[i]);
      end
   endtask

   task automatic frame_interrupt();
      logic [7:0] d;
      logic       rq;
      vdp_reg_write(6'd1, 8'h20);
      frame_pulse();
      check_bit("vdp_int_n", vdp_int_n, 1'b0);
      io_read(8'h99, d, rq);
      check_byte("d_to_cpu", d, 8'h80);
      check_bit("vdp_int_n", vdp_int_n, 1'b1);
      io_read(8'h99, d, rq);
      check_byte("d_to_cpu", d, 8'h00);
      // Flag stays pending with the interrupt masked
      vdp_reg_write(6'd1, 8'h00);
      frame_pulse();
      check_bit("vdp_int_n", vdp_int_n, 1'b1);
   endtask

   task automatic clock_counting();
      int         tot;
      logic [7:0] d;
      logic       rq;
      tot = bcd_secs(rtc_time);
      for (int r = 0; r < 6; r++) begin
         io_write(8'hB4, 8'(r));
         io_read(8'hB5, d, rq);
         check_byte("d_to_cpu", d, {4'hF, time_digit(tot, r)});
      end
      repeat (20) tick_pulse();
      tot = (tot + 20 / RTC_TICKS_DEFAULT) % 86400;
      for (int r = 0; r < 6; r++) begin
         io_write(8'hB4, 8'(r));
         io_read(8'hB5, d, rq);
         check_byte("d_to_cpu", d, {4'hF, time_digit(tot, r)});
      end
      io_write(8'hB4, 8'h09);
      io_write(8'hB5, 8'h07);
      io_read(8'hB5, d, rq);
      check_byte("d_to_cpu", d, 8'hF7);
   endtask

   task automatic port_decoding();
      logic [7:0] d;
      logic       rq;
      vdp_reg_write(6'd1, 8'h20);
      check_bit("vdp_int_n", vdp_int_n, 1'b0);
      // Interrupt acknowledge at 99h must not touch the VDP
      drive_bus(16'h0099, 8'h00, 1'b0, 1'b1, 1'b1);
      end_cycle(d, rq);
      check_bit("data_bus_rq", rq, 1'b0);
      check_bit("vdp_int_n", vdp_int_n, 1'b0);
      io_read(8'h9F, d, rq);
      check_bit("data_bus_rq", rq, 1'b1);
      check_byte("d_to_cpu", d, 8'h80);
      io_read(8'h97, d, rq);
      check_byte("d_to_cpu", d, 8'hFF);
      check_bit("data_bus_rq", rq, 1'b0);
      io_read(8'hB6, d, rq);
      check_byte("d_to_cpu", d, 8'hFF);
      check_bit("data_bus_rq", rq, 1'b0);
      drive_bus(16'h0098, 8'h00, 1'b0, 1'b0, 1'b0);
      end_cycle(d, rq);
      check_bit("data_bus_rq", rq, 1'b0);
   endtask

   initial begin
      seed       = 32'hb52d4bda;
      cycles     = 0;
      we_lo_seen = 1'b0;
      reset      = 1'b1;
      ce_10hz    = 1'b0;
      frame_tick = 1'b0;
      bus        = '{addr: 16'h0000, dout: 8'h00, wr_n: 1'b1, rd_n: 1'b1,
                     iorq_n: 1'b1, mreq_n: 1'b1, m1_n: 1'b1, spare: 3'b111};
      rtc_time   = '{hour: 8'h23, min: 8'h59, sec: 8'h58};
      for (int a = 0; a < 65536; a++) begin
         bank_lo[a] = 8'(a ^ (a >> 8));
         bank_hi[a] = 8'(a ^ (a >> 8) ^ 8'hA5);
      end
      repeat (5) @(negedge clk21m);
      reset = 1'b0;
      reset_state();
      vram_access();
      frame_interrupt();
      clock_counting();
      port_decoding();
      repeat (2) @(negedge clk21m);
      if (u_dut.u_chk.fail_count == 0) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         $display("Bound assertions failed %0d times", u_dut.u_chk.fail_count);
         $display("TEST FAILED");
         $fatal(1, "Assertion failures");
      end
   end

endmodule
